// File: hdl/mcu_pkg.sv
/*
 * Shared definitions for the mini MCU subsystem
 *   - OBI-style request and response structs
 *   - address map of the two RAM banks and the peripheral window
 *   - register offsets inside the peripheral window
 *   - copy job descriptor from the register block to the copy engine
 */

package mcu_pkg;

  // request driven by a bus master, held until gnt
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  // gnt belongs to the current cycle, the rest to the cycle after the grant
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } obi_resp_t;

  // total RAM, split into two banks by the top level
  localparam int unsigned MEM_SIZE = 32'h0001_0000;

  localparam logic [31:0] RAM0_START_ADDRESS   = 32'h0000_0000;
  localparam logic [31:0] RAM1_START_ADDRESS   = 32'h0000_8000;
  localparam logic [31:0] PERIPH_START_ADDRESS = 32'h2000_0000;
  localparam int unsigned PERIPH_SIZE          = 32'h0000_1000;

  localparam logic [11:0] EXIT_VALUE_OFFSET = 12'h000;
  localparam logic [11:0] DMA_SRC_OFFSET    = 12'h004;
  localparam logic [11:0] DMA_DST_OFFSET    = 12'h008;
  localparam logic [11:0] DMA_LEN_OFFSET    = 12'h00C;
  localparam logic [11:0] DMA_CTRL_OFFSET   = 12'h010;

  // start is a single-cycle pulse, len counts 32-bit words
  typedef struct packed {
    logic [31:0] src;
    logic [31:0] dst;
    logic [15:0] len;
    logic        start;
  } dma_cfg_t;

endpackage

// File: hdl/sram_bank.sv
/*
 * sram_bank: single-port word RAM
 *   - per-byte write enables
 *   - registered read data and rvalid, one cycle after req
 */

`timescale 1ns/10ps

module sram_bank #(
  parameter int unsigned NUM_BYTES = 32768
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           req_i,
  input  logic                           we_i,
  input  logic [3:0]                     be_i,
  input  logic [$clog2(NUM_BYTES/4)-1:0] word_addr_i,
  input  logic [31:0]                    wdata_i,
  output logic [31:0]                    rdata_o,
  output logic                           rvalid_o
);

  localparam int unsigned NUM_WORDS = NUM_BYTES / 4;

  logic [31:0] mem [NUM_WORDS];

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int i = 0; i < 4; i++) begin
        if (be_i[i]) begin
          mem[word_addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  // a write returns the old word, the bus only cares about rvalid then
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= mem[word_addr_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

endmodule

// File: hdl/memory_subsystem.sv
/*
 * memory_subsystem: the two RAM banks
 *   - base address removal and word indexing
 *   - immediate grant, bank responses forwarded as OBI responses
 *   - range checks of the bank-local offsets
 */

`timescale 1ns/10ps

module memory_subsystem #(
  parameter int unsigned NUM_BYTES = 32768
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  mcu_pkg::obi_req_t  ram0_req_i,
  output mcu_pkg::obi_resp_t ram0_resp_o,
  input  mcu_pkg::obi_req_t  ram1_req_i,
  output mcu_pkg::obi_resp_t ram1_resp_o
);

  import mcu_pkg::*;

  localparam int unsigned ADDR_W = $clog2(NUM_BYTES / 4);

  logic [31:0] ram0_offset;
  logic [31:0] ram1_offset;
  logic [31:0] ram0_rdata;
  logic [31:0] ram1_rdata;
  logic        ram0_rvalid;
  logic        ram1_rvalid;

  // bank-local byte offset, the low two bits are covered by be
  assign ram0_offset = ram0_req_i.addr - RAM0_START_ADDRESS;
  assign ram1_offset = ram1_req_i.addr - RAM1_START_ADDRESS;

  sram_bank #(
    .NUM_BYTES(NUM_BYTES)
  ) ram0_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (ram0_req_i.req),
    .we_i       (ram0_req_i.we),
    .be_i       (ram0_req_i.be),
    .word_addr_i(ram0_offset[ADDR_W+1:2]),
    .wdata_i    (ram0_req_i.wdata),
    .rdata_o    (ram0_rdata),
    .rvalid_o   (ram0_rvalid)
  );

  sram_bank #(
    .NUM_BYTES(NUM_BYTES)
  ) ram1_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (ram1_req_i.req),
    .we_i       (ram1_req_i.we),
    .be_i       (ram1_req_i.be),
    .word_addr_i(ram1_offset[ADDR_W+1:2]),
    .wdata_i    (ram1_req_i.wdata),
    .rdata_o    (ram1_rdata),
    .rvalid_o   (ram1_rvalid)
  );

  assign ram0_resp_o = '{gnt: ram0_req_i.req, rvalid: ram0_rvalid, err: 1'b0, rdata: ram0_rdata};
  assign ram1_resp_o = '{gnt: ram1_req_i.req, rvalid: ram1_rvalid, err: 1'b0, rdata: ram1_rdata};

  // the bus decode and the bank size must agree, otherwise high offset bits vanish
  ram0_offset_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ram0_req_i.req |-> (ram0_offset < NUM_BYTES));

  ram1_offset_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ram1_req_i.req |-> (ram1_offset < NUM_BYTES));

endmodule

// File: hdl/system_bus.sv
/*
 * system_bus: two-master, three-slave crossbar
 *   - fixed priority, host over copy engine
 *   - address decode against the package address map
 *   - response routing one cycle after the grant
 *   - error responses for unmapped addresses
 */

`timescale 1ns/10ps

module system_bus #(
  parameter int unsigned NUM_BYTES = 32768
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  mcu_pkg::obi_req_t  host_req_i,
  output mcu_pkg::obi_resp_t host_resp_o,
  input  mcu_pkg::obi_req_t  dma_req_i,
  output mcu_pkg::obi_resp_t dma_resp_o,
  output mcu_pkg::obi_req_t  ram0_req_o,
  input  mcu_pkg::obi_resp_t ram0_resp_i,
  output mcu_pkg::obi_req_t  ram1_req_o,
  input  mcu_pkg::obi_resp_t ram1_resp_i,
  output mcu_pkg::obi_req_t  periph_req_o,
  input  mcu_pkg::obi_resp_t periph_resp_i
);

  import mcu_pkg::*;

  localparam logic [1:0] SLV_RAM0   = 2'd0;
  localparam logic [1:0] SLV_RAM1   = 2'd1;
  localparam logic [1:0] SLV_PERIPH = 2'd2;
  localparam logic [1:0] SLV_NONE   = 2'd3;

  // unsigned subtraction folds the lower and upper bound into one compare
  function automatic logic [1:0] decode_addr(input logic [31:0] addr);
    logic [1:0] slave;
    if ((addr - RAM0_START_ADDRESS) < NUM_BYTES) begin
      slave = SLV_RAM0;
    end else if ((addr - RAM1_START_ADDRESS) < NUM_BYTES) begin
      slave = SLV_RAM1;
    end else if ((addr - PERIPH_START_ADDRESS) < PERIPH_SIZE) begin
      slave = SLV_PERIPH;
    end else begin
      slave = SLV_NONE;
    end
    return slave;
  endfunction

  obi_req_t   sel_req;
  obi_resp_t  slave_resp;
  logic       sel_host;
  logic [1:0] sel_slave;
  logic       sel_gnt;
  logic       rsp_pending_q;
  logic       rsp_host_q;
  logic [1:0] rsp_slave_q;

  // the host always wins, the copy engine keeps its req up until granted
  always_comb begin
    sel_host  = host_req_i.req;
    sel_req   = sel_host ? host_req_i : dma_req_i;
    sel_slave = decode_addr(sel_req.addr);
  end

  always_comb begin
    ram0_req_o       = sel_req;
    ram0_req_o.req   = sel_req.req && (sel_slave == SLV_RAM0);
    ram1_req_o       = sel_req;
    ram1_req_o.req   = sel_req.req && (sel_slave == SLV_RAM1);
    periph_req_o     = sel_req;
    periph_req_o.req = sel_req.req && (sel_slave == SLV_PERIPH);
    case (sel_slave)
      SLV_RAM0:   sel_gnt = ram0_resp_i.gnt;
      SLV_RAM1:   sel_gnt = ram1_resp_i.gnt;
      SLV_PERIPH: sel_gnt = periph_resp_i.gnt;
      default:    sel_gnt = sel_req.req;
    endcase
  end

  // remember who got the grant so the response finds its way back
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_pending_q <= 1'b0;
      rsp_host_q    <= 1'b0;
      rsp_slave_q   <= SLV_NONE;
    end else begin
      rsp_pending_q <= sel_gnt;
      if (sel_gnt) begin
        rsp_host_q  <= sel_host;
        rsp_slave_q <= sel_slave;
      end
    end
  end

  always_comb begin
    case (rsp_slave_q)
      SLV_RAM0:   slave_resp = ram0_resp_i;
      SLV_RAM1:   slave_resp = ram1_resp_i;
      SLV_PERIPH: slave_resp = periph_resp_i;
      default: begin
        slave_resp        = '0;
        slave_resp.rvalid = rsp_pending_q;
        slave_resp.err    = 1'b1;
      end
    endcase
    host_resp_o     = '0;
    dma_resp_o      = '0;
    host_resp_o.gnt = sel_gnt && sel_host;
    dma_resp_o.gnt  = sel_gnt && !sel_host;
    if (rsp_pending_q && rsp_host_q) begin
      host_resp_o.rvalid = slave_resp.rvalid;
      host_resp_o.err    = slave_resp.err;
      host_resp_o.rdata  = slave_resp.rdata;
    end else if (rsp_pending_q) begin
      dma_resp_o.rvalid = slave_resp.rvalid;
      dma_resp_o.err    = slave_resp.err;
      dma_resp_o.rdata  = slave_resp.rdata;
    end
  end

  // a slave answering without a grant in the previous cycle would be dropped unseen
  ram0_rvalid_follows_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ram0_resp_i.rvalid |-> (rsp_pending_q && (rsp_slave_q == SLV_RAM0)));

  ram1_rvalid_follows_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ram1_resp_i.rvalid |-> (rsp_pending_q && (rsp_slave_q == SLV_RAM1)));

  periph_rvalid_follows_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    periph_resp_i.rvalid |-> (rsp_pending_q && (rsp_slave_q == SLV_PERIPH)));

endmodule

// File: hdl/peripheral_subsystem.sv
/*
 * peripheral_subsystem: memory-mapped register block
 *   - exit value register with sticky valid flag
 *   - copy engine source, destination, length and control
 *   - start pulse generation and busy status readback
 */

`timescale 1ns/10ps

module peripheral_subsystem (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  mcu_pkg::obi_req_t  slave_req_i,
  output mcu_pkg::obi_resp_t slave_resp_o,
  output mcu_pkg::dma_cfg_t  dma_cfg_o,
  input  logic               dma_busy_i,
  output logic [31:0]        exit_value_o,
  output logic               exit_valid_o
);

  import mcu_pkg::*;

  function automatic logic [31:0] merge_be(input logic [31:0] old_val,
                                           input logic [31:0] new_val,
                                           input logic [3:0]  be);
    logic [31:0] result;
    result = old_val;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        result[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return result;
  endfunction

  logic [11:0] offset;
  logic        wr_en;
  logic        offset_hit;
  logic        busy;
  logic        start_q;
  logic [31:0] src_q;
  logic [31:0] dst_q;
  logic [15:0] len_q;
  logic [31:0] len_merged;
  logic [31:0] rdata_q;
  logic        rvalid_q;
  logic        err_q;

  assign offset     = slave_req_i.addr[11:0];
  assign wr_en      = slave_req_i.req && slave_req_i.we;
  assign offset_hit = (offset == EXIT_VALUE_OFFSET) || (offset == DMA_SRC_OFFSET) ||
                      (offset == DMA_DST_OFFSET) || (offset == DMA_LEN_OFFSET) ||
                      (offset == DMA_CTRL_OFFSET);
  assign len_merged = merge_be({16'h0000, len_q}, slave_req_i.wdata, slave_req_i.be);

  // the engine only raises busy a cycle after the pulse, so cover that gap
  assign busy = dma_busy_i || start_q;

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      case (offset)
        EXIT_VALUE_OFFSET: exit_value_o <= merge_be(exit_value_o, slave_req_i.wdata, slave_req_i.be);
        DMA_SRC_OFFSET:    src_q <= merge_be(src_q, slave_req_i.wdata, slave_req_i.be);
        DMA_DST_OFFSET:    dst_q <= merge_be(dst_q, slave_req_i.wdata, slave_req_i.be);
        DMA_LEN_OFFSET:    len_q <= len_merged[15:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_valid_o <= 1'b0;
      start_q      <= 1'b0;
    end else begin
      if (wr_en && (offset == EXIT_VALUE_OFFSET)) begin
        exit_valid_o <= 1'b1;
      end
      // a start request while a job runs is dropped
      start_q <= wr_en && (offset == DMA_CTRL_OFFSET) && slave_req_i.be[0] &&
                 slave_req_i.wdata[0] && !busy;
    end
  end

  always_ff @(posedge clk_i) begin
    case (offset)
      EXIT_VALUE_OFFSET: rdata_q <= exit_value_o;
      DMA_SRC_OFFSET:    rdata_q <= src_q;
      DMA_DST_OFFSET:    rdata_q <= dst_q;
      DMA_LEN_OFFSET:    rdata_q <= {16'h0000, len_q};
      DMA_CTRL_OFFSET:   rdata_q <= {31'h0, busy};
      default:           rdata_q <= 32'h0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= slave_req_i.req;
      err_q    <= slave_req_i.req && !offset_hit;
    end
  end

  assign slave_resp_o = '{gnt: slave_req_i.req, rvalid: rvalid_q, err: err_q, rdata: rdata_q};
  assign dma_cfg_o    = '{src: src_q, dst: dst_q, len: len_q, start: start_q};

endmodule

// File: hdl/dma_engine.sv
/*
 * dma_engine: word copy engine on bus master 1
 *   - FSM with idle, read request, read wait and write request phases
 *   - word countdown with source and destination stepping by 4
 *   - aborts the job on a read error response
 */

`timescale 1ns/10ps

module dma_engine (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  mcu_pkg::dma_cfg_t  cfg_i,
  output mcu_pkg::obi_req_t  master_req_o,
  input  mcu_pkg::obi_resp_t master_resp_i,
  output logic               busy_o
);

  import mcu_pkg::*;

  typedef enum logic [1:0] {
    DMA_IDLE,
    DMA_RD_REQ,
    DMA_RD_WAIT,
    DMA_WR_REQ
  } dma_state_e;

  dma_state_e  state_q;
  dma_state_e  state_d;
  logic [15:0] count_q;
  logic [31:0] src_q;
  logic [31:0] dst_q;
  logic [31:0] data_q;
  logic        job_start;

  // a zero-length job never leaves idle
  assign job_start = (state_q == DMA_IDLE) && cfg_i.start && (cfg_i.len != 16'h0000);

  always_comb begin
    state_d = state_q;
    case (state_q)
      DMA_IDLE: begin
        if (job_start) begin
          state_d = DMA_RD_REQ;
        end
      end
      DMA_RD_REQ: begin
        if (master_resp_i.gnt) begin
          state_d = DMA_RD_WAIT;
        end
      end
      DMA_RD_WAIT: begin
        if (master_resp_i.rvalid) begin
          state_d = master_resp_i.err ? DMA_IDLE : DMA_WR_REQ;
        end
      end
      DMA_WR_REQ: begin
        if (master_resp_i.gnt) begin
          state_d = (count_q == 16'd1) ? DMA_IDLE : DMA_RD_REQ;
        end
      end
      default: state_d = DMA_IDLE;
    endcase
  end

  always_comb begin
    master_req_o = '0;
    if (state_q == DMA_RD_REQ) begin
      master_req_o.req  = 1'b1;
      master_req_o.be   = 4'hF;
      master_req_o.addr = src_q;
    end else if (state_q == DMA_WR_REQ) begin
      master_req_o.req   = 1'b1;
      master_req_o.we    = 1'b1;
      master_req_o.be    = 4'hF;
      master_req_o.addr  = dst_q;
      master_req_o.wdata = data_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= DMA_IDLE;
      count_q <= 16'h0000;
    end else begin
      state_q <= state_d;
      if (job_start) begin
        count_q <= cfg_i.len;
      end else if ((state_q == DMA_WR_REQ) && master_resp_i.gnt) begin
        count_q <= count_q - 16'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (job_start) begin
      src_q <= cfg_i.src;
      dst_q <= cfg_i.dst;
    end else if ((state_q == DMA_WR_REQ) && master_resp_i.gnt) begin
      src_q <= src_q + 32'd4;
      dst_q <= dst_q + 32'd4;
    end
    if ((state_q == DMA_RD_WAIT) && master_resp_i.rvalid) begin
      data_q <= master_resp_i.rdata;
    end
  end

  assign busy_o = (state_q != DMA_IDLE);

  // read wait lasts a single cycle, so every grant must be answered right after it
  rvalid_follows_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    master_resp_i.gnt |=> master_resp_i.rvalid);

endmodule

// File: hdl/mini_mcu.sv
/*
 * mini_mcu: subsystem top level
 *   - system bus with host port and copy engine as masters
 *   - two RAM banks and the register block as slaves
 */

`timescale 1ns/10ps

module mini_mcu #(
  parameter int unsigned NUM_BYTES = mcu_pkg::MEM_SIZE / 2
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  mcu_pkg::obi_req_t  host_req_i,
  output mcu_pkg::obi_resp_t host_resp_o,
  output logic [31:0]        exit_value_o,
  output logic               exit_valid_o
);

  import mcu_pkg::*;

  obi_req_t  dma_req;
  obi_resp_t dma_resp;
  obi_req_t  ram0_req;
  obi_resp_t ram0_resp;
  obi_req_t  ram1_req;
  obi_resp_t ram1_resp;
  obi_req_t  periph_req;
  obi_resp_t periph_resp;
  dma_cfg_t  dma_cfg;
  logic      dma_busy;

  system_bus #(
    .NUM_BYTES(NUM_BYTES)
  ) system_bus_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .host_req_i   (host_req_i),
    .host_resp_o  (host_resp_o),
    .dma_req_i    (dma_req),
    .dma_resp_o   (dma_resp),
    .ram0_req_o   (ram0_req),
    .ram0_resp_i  (ram0_resp),
    .ram1_req_o   (ram1_req),
    .ram1_resp_i  (ram1_resp),
    .periph_req_o (periph_req),
    .periph_resp_i(periph_resp)
  );

  memory_subsystem #(
    .NUM_BYTES(NUM_BYTES)
  ) memory_subsystem_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ram0_req_i (ram0_req),
    .ram0_resp_o(ram0_resp),
    .ram1_req_i (ram1_req),
    .ram1_resp_o(ram1_resp)
  );

  peripheral_subsystem peripheral_subsystem_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .slave_req_i (periph_req),
    .slave_resp_o(periph_resp),
    .dma_cfg_o   (dma_cfg),
    .dma_busy_i  (dma_busy),
    .exit_value_o(exit_value_o),
    .exit_valid_o(exit_valid_o)
  );

  dma_engine dma_engine_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cfg_i        (dma_cfg),
    .master_req_o (dma_req),
    .master_resp_i(dma_resp),
    .busy_o       (dma_busy)
  );

endmodule

// File: testbench/tb_clock_gen.sv
/*
 * Clock and reset source for the testbench
 *   - free-running 10 ns clock
 *   - active-low reset held for 10 rising edges
 */

`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset is released just after an edge, like the other stimulus
  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

// File: testbench/tb_mini_mcu.sv
/*
 * Testbench for the mini MCU subsystem
 *   - vector file driven host transfers on the OBI-style port
 *   - word model of both RAM banks, random fill from an LCG
 *   - copy engine runs with host traffic in between
 *   - exit register checks and a cycle-budget watchdog
 */

`timescale 1ns/10ps

module tb_mini_mcu;

  import mcu_pkg::*;

  localparam int MAX_VEC   = 64;
  localparam int VEC_COLS  = 5;
  localparam int RAM_WORDS = MEM_SIZE / 4;

  logic        clk;
  logic        rst_n;
  obi_req_t    host_req;
  obi_resp_t   host_resp;
  logic [31:0] exit_value;
  logic        exit_valid;

  logic [31:0] vec_mem [MAX_VEC*VEC_COLS];
  logic [31:0] model [RAM_WORDS];
  logic [31:0] rng_state;
  int          n_vec;
  int          copy_words;
  int          limit_cycles = 0;
  int          n_checks;
  int          n_errors;
  logic        exit_seen;

  tb_clock_gen clock_gen_inst (
    .clk_o  (clk),
    .rst_n_o(rst_n)
  );

  mini_mcu mini_mcu_inst (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .host_req_i  (host_req),
    .host_resp_o (host_resp),
    .exit_value_o(exit_value),
    .exit_valid_o(exit_valid)
  );

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // byte lanes selected by be come from the new word
  function automatic logic [31:0] apply_be(input logic [31:0] old_word,
                                           input logic [31:0] new_word,
                                           input logic [3:0]  be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  // both banks together cover the first 64 KiB
  function automatic int word_index(input logic [31:0] addr);
    return int'(addr[15:2]);
  endfunction

  function automatic logic [31:0] reg_addr(input logic [11:0] offset);
    return PERIPH_START_ADDRESS + {20'h0, offset};
  endfunction

  task automatic check_value(input string name, input logic [31:0] addr,
                             input logic [31:0] expected, input logic [31:0] actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("Fail %s at %08h: expected %08h, got %08h", name, addr, expected, actual);
    end
  endtask

  // one host transfer, req held until gnt, response taken the cycle after
  task automatic bus_xfer(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] be, output logic [31:0] rdata, output logic err);
    @(posedge clk);
    #1;
    host_req = '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
    @(negedge clk);
    while (!host_resp.gnt) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    host_req = '0;
    @(negedge clk);
    n_checks++;
    if (!host_resp.rvalid) begin
      n_errors++;
      $display("No response arrived one cycle after the grant for address %08h", addr);
    end
    rdata = host_resp.rdata;
    err   = host_resp.err;
    check_value("exit_valid_o", addr, {31'h0, exit_seen}, {31'h0, exit_valid});
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] be);
    logic [31:0] rdata;
    logic        err;
    bus_xfer(1'b1, addr, data, be, rdata, err);
    check_value("host_resp_o.err", addr, 32'h0, {31'h0, err});
    if (addr < MEM_SIZE) begin
      model[word_index(addr)] = apply_be(model[word_index(addr)], data, be);
    end
  endtask

  task automatic bus_read_check(input logic [31:0] addr, input logic [31:0] expected);
    logic [31:0] rdata;
    logic        err;
    bus_xfer(1'b0, addr, 32'h0, 4'hF, rdata, err);
    check_value("host_resp_o.err", addr, 32'h0, {31'h0, err});
    check_value("host_resp_o.rdata", addr, expected, rdata);
  endtask

  task automatic run_copy(input logic [31:0] src, input logic [31:0] dst, input int count);
    logic [31:0] rdata;
    logic        err;
    int          polls;
    bus_write(reg_addr(DMA_SRC_OFFSET), src, 4'hF);
    bus_write(reg_addr(DMA_DST_OFFSET), dst, 4'hF);
    bus_write(reg_addr(DMA_LEN_OFFSET), 32'(count), 4'hF);
    bus_read_check(reg_addr(DMA_SRC_OFFSET), src);
    bus_read_check(reg_addr(DMA_DST_OFFSET), dst);
    bus_read_check(reg_addr(DMA_LEN_OFFSET), 32'(count));
    bus_write(reg_addr(DMA_CTRL_OFFSET), 32'h1, 4'hF);
    // source reads compete with the engine for the bus
    for (int i = 0; i < 4; i++) begin
      bus_read_check(src + 32'(4 * i), model[word_index(src) + i]);
    end
    bus_read_check(reg_addr(DMA_CTRL_OFFSET), 32'h1);
    // a restart would pick up the longer length and spill past the destination
    bus_write(reg_addr(DMA_LEN_OFFSET), 32'(count + 4), 4'hF);
    bus_read_check(reg_addr(DMA_LEN_OFFSET), 32'(count + 4));
    bus_write(reg_addr(DMA_CTRL_OFFSET), 32'h1, 4'hF);
    polls = 0;
    rdata = 32'h1;
    while (rdata[0] && (polls < 8 * count + 64)) begin
      bus_xfer(1'b0, reg_addr(DMA_CTRL_OFFSET), 32'h0, 4'hF, rdata, err);
      polls++;
    end
    n_checks++;
    if (rdata[0]) begin
      n_errors++;
      $display("Copy engine still busy after %0d status reads", polls);
    end
    // the words just past the destination keep their old values
    for (int i = count; i < count + 4; i++) begin
      bus_read_check(dst + 32'(4 * i), model[word_index(dst) + i]);
    end
    for (int i = 0; i < count; i++) begin
      model[word_index(dst) + i] = model[word_index(src) + i];
    end
  endtask

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout, the run did not end within %0d cycles", limit_cycles);
    $display("%0d checks, %0d errors", n_checks, n_errors);
    $display("Checks failed");
    $finish;
  end

  initial begin
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expv;
    logic [31:0] rdata;
    logic        err;
    host_req   = '0;
    rng_state  = 32'h03d37543;
    n_checks   = 0;
    n_errors   = 0;
    exit_seen  = 1'b0;
    n_vec      = 0;
    copy_words = 0;
    for (int i = 0; i < MAX_VEC * VEC_COLS; i++) begin
      vec_mem[i] = 32'h0;
    end
    $readmemh("testbench/mcu_vectors.txt", vec_mem);
    while ((n_vec < MAX_VEC) && (vec_mem[n_vec*VEC_COLS] != 32'h0)) begin
      if (vec_mem[n_vec*VEC_COLS] == 32'h6) begin
        copy_words += int'(vec_mem[n_vec*VEC_COLS + 4]);
      end
      n_vec++;
    end
    limit_cycles = 20 + 200 * (n_vec + 1) + 4 * copy_words;
    if (n_vec == 0) begin
      n_errors++;
      $display("No vector lines were read from the vector file");
    end
    wait (rst_n);
    @(negedge clk);
    check_value("host_resp_o.gnt", 32'h0, 32'h0, {31'h0, host_resp.gnt});
    check_value("host_resp_o.rvalid", 32'h0, 32'h0, {31'h0, host_resp.rvalid});
    check_value("exit_valid_o", 32'h0, 32'h0, {31'h0, exit_valid});
    for (int v = 0; v < n_vec; v++) begin
      op   = vec_mem[v*VEC_COLS];
      addr = vec_mem[v*VEC_COLS + 1];
      data = vec_mem[v*VEC_COLS + 2];
      expv = vec_mem[v*VEC_COLS + 4];
      case (op)
        32'h1: bus_write(addr, data, vec_mem[v*VEC_COLS + 3][3:0]);
        32'h2: bus_read_check(addr, model[word_index(addr)]);
        32'h3: bus_read_check(addr, expv);
        32'h4: begin
          bus_xfer(1'b0, addr, 32'h0, 4'hF, rdata, err);
          check_value("host_resp_o.err", addr, 32'h1, {31'h0, err});
          check_value("host_resp_o.rdata", addr, 32'h0, rdata);
        end
        32'h5: begin
          for (int i = 0; i < int'(expv); i++) begin
            bus_write(addr + 32'(4 * i), next_random(), 4'hF);
          end
        end
        32'h6: run_copy(addr, data, int'(expv));
        32'h7: begin
          exit_seen = 1'b1;
          bus_write(addr, data, 4'hF);
          check_value("exit_value_o", addr, data, exit_value);
        end
        32'h8: begin
          for (int i = 0; i < int'(expv); i++) begin
            bus_read_check(addr + 32'(4 * i), model[word_index(addr) + i]);
          end
        end
        default: begin
          n_errors++;
          $display("Unknown operation %0h on vector line %0d", op, v);
        end
      endcase
    end
    $display("%0d vectors, %0d checks, %0d errors", n_vec, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: testbench/mcu_vectors.txt
// columns: op addr data be expected, all hex
// op 1 write, 2 read vs RAM model, 3 read vs expected, 4 read expecting error,
// 5 random fill, 6 copy from addr to data, 7 exit write, 8 compare with model
// for ops 5, 6 and 8 the expected column is the word count
1 00000000 11223344 f 00000000
1 00000004 55667788 f 00000000
1 00008000 a5a5a5a5 f 00000000
1 0000fffc 0badf00d f 00000000
2 00000000 00000000 f 00000000
2 00000004 00000000 f 00000000
2 00008000 00000000 f 00000000
2 0000fffc 00000000 f 00000000
1 00000004 000000cc 1 00000000
1 00008000 dd00ee00 a 00000000
2 00000004 00000000 f 00000000
2 00008000 00000000 f 00000000
4 10000000 00000000 f 00000000
4 20001000 00000000 f 00000000
4 40000000 00000000 f 00000000
5 00000100 00000000 f 00000020
5 000080f0 00000000 f 00000030
6 00000100 00008100 f 00000018
8 000080f0 00000000 f 00000030
8 00000100 00000000 f 00000020
3 20000010 00000000 f 00000000
7 20000000 cafe0001 f 00000000
5 000003f0 00000000 f 00000020
6 00008100 00000400 f 00000010
8 000003f0 00000000 f 00000020
1 00000008 12345678 f 00000000
2 00000008 00000000 f 00000000
7 20000000 00c0ffee f 00000000
3 20000000 00000000 f 00c0ffee

// File: list.f
hdl/mcu_pkg.sv
hdl/sram_bank.sv
hdl/memory_subsystem.sv
hdl/system_bus.sv
hdl/peripheral_subsystem.sv
hdl/dma_engine.sv
hdl/mini_mcu.sv
testbench/tb_clock_gen.sv
testbench/tb_mini_mcu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run from the project root, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

{ verilator --binary --assert --top-module tb_mini_mcu -f list.f \
    -Mdir obj_dir -o sim_mini_mcu \
  && ./obj_dir/sim_mini_mcu; } > sim.log 2>&1 \
  || echo "Checks failed" >> sim.log

cat sim.log
grep -q "Checks failed" sim.log \
  && { echo "RESULT: FAIL"; exit 1; } \
  || { echo "RESULT: PASS"; exit 0; }
